//--- design/wb_pkg.sv
// ----------------------------------------------------------
// Shared widths, write-value select codes and queue sizing
// for the writeback and retire path. Modules reference these
// by scoped name.
// ----------------------------------------------------------
package wb_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int order_w    = 64;
    localparam int wb_sel_w   = 4;

    // register write-value select codes
    localparam logic [wb_sel_w-1:0] sel_alu_out  = 4'd0;
    localparam logic [wb_sel_w-1:0] sel_br_en    = 4'd1;
    localparam logic [wb_sel_w-1:0] sel_u_imm    = 4'd2;
    localparam logic [wb_sel_w-1:0] sel_lw       = 4'd3;
    localparam logic [wb_sel_w-1:0] sel_pc_plus4 = 4'd4;
    localparam logic [wb_sel_w-1:0] sel_lb       = 4'd5;
    localparam logic [wb_sel_w-1:0] sel_lbu      = 4'd6; // unsigned byte
    localparam logic [wb_sel_w-1:0] sel_lh       = 4'd7;
    localparam logic [wb_sel_w-1:0] sel_lhu      = 4'd8; // unsigned halfword

    localparam int wb_queue_depth = 4;  // also credits at reset
    localparam int credit_w       = 3;
    localparam int qptr_w         = 2;

    localparam logic [xlen-1:0] reset_pc = 32'h4000_0000; // idle retire pc

    // aligned memory word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

//--- design/wb_entry_queue.sv
// ----------------------------------------------------------
// Credit-managed FIFO between the memory stage and writeback.
// Upstream holds one credit per free entry; a credit comes
// back one cycle after each entry is popped.
// ----------------------------------------------------------
`timescale 1ns/1ps

module wb_entry_queue (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  logic [wb_pkg::reg_addr_w-1:0] in_rd,
    input  logic [wb_pkg::wb_sel_w-1:0]   in_sel,
    input  logic                          in_ld_reg,
    input  logic                          in_is_store,
    input  logic [wb_pkg::xlen-1:0]       in_alu_out,
    input  logic                          in_br_en,
    input  logic [wb_pkg::xlen-1:0]       in_u_imm,
    input  logic [wb_pkg::xlen-1:0]       in_mem_rdata,
    input  logic [1:0]                    in_mem_offset,
    input  logic [wb_pkg::xlen-1:0]       in_pc,
    input  logic [wb_pkg::order_w-1:0]    in_order,
    input  logic                          pop,
    input  logic                          retire_hold,
    output logic                          head_valid,
    output logic [wb_pkg::reg_addr_w-1:0] head_rd,
    output logic [wb_pkg::wb_sel_w-1:0]   head_sel,
    output logic                          head_ld_reg,
    output logic                          head_is_store,
    output logic [wb_pkg::xlen-1:0]       head_alu_out,
    output logic                          head_br_en,
    output logic [wb_pkg::xlen-1:0]       head_u_imm,
    output logic [wb_pkg::xlen-1:0]       head_mem_rdata,
    output logic [1:0]                    head_mem_offset,
    output logic [wb_pkg::xlen-1:0]       head_pc,
    output logic [wb_pkg::order_w-1:0]    head_order,
    output logic                          credit_return
);

    localparam int depth = wb_pkg::wb_queue_depth;

    // entry storage
    logic [wb_pkg::reg_addr_w-1:0] rd_q      [depth];
    logic [wb_pkg::wb_sel_w-1:0]   sel_q     [depth];
    logic                          ld_reg_q  [depth];
    logic                          store_q   [depth];
    logic [wb_pkg::xlen-1:0]       alu_q     [depth];
    logic                          br_q      [depth];
    logic [wb_pkg::xlen-1:0]       uimm_q    [depth];
    logic [wb_pkg::xlen-1:0]       rdata_q   [depth];
    logic [1:0]                    offset_q  [depth];
    logic [wb_pkg::xlen-1:0]       pc_q      [depth];
    logic [wb_pkg::order_w-1:0]    order_q   [depth];

    logic [wb_pkg::qptr_w-1:0]   wr_ptr;
    logic [wb_pkg::qptr_w-1:0]   rd_ptr;
    logic [wb_pkg::credit_w-1:0] count;
    logic                        do_pop;

    assign head_valid = (count != '0);
    assign do_pop     = pop && head_valid && !retire_hold;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rd_q[wr_ptr]     <= in_rd;
            sel_q[wr_ptr]    <= in_sel;
            ld_reg_q[wr_ptr] <= in_ld_reg;
            store_q[wr_ptr]  <= in_is_store;
            alu_q[wr_ptr]    <= in_alu_out;
            br_q[wr_ptr]     <= in_br_en;
            uimm_q[wr_ptr]   <= in_u_imm;
            rdata_q[wr_ptr]  <= in_mem_rdata;
            offset_q[wr_ptr] <= in_mem_offset;
            pc_q[wr_ptr]     <= in_pc;
            order_q[wr_ptr]  <= in_order;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid)
                wr_ptr <= wr_ptr + wb_pkg::qptr_w'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + wb_pkg::qptr_w'(1);
            count         <= count + wb_pkg::credit_w'(in_valid)
                                   - wb_pkg::credit_w'(do_pop);
            credit_return <= do_pop; // one credit per pop, next cycle
        end
    end

    assign head_rd         = rd_q[rd_ptr];
    assign head_sel        = sel_q[rd_ptr];
    assign head_ld_reg     = ld_reg_q[rd_ptr];
    assign head_is_store   = store_q[rd_ptr];
    assign head_alu_out    = alu_q[rd_ptr];
    assign head_br_en      = br_q[rd_ptr];
    assign head_u_imm      = uimm_q[rd_ptr];
    assign head_mem_rdata  = rdata_q[rd_ptr];
    assign head_mem_offset = offset_q[rd_ptr];
    assign head_pc         = pc_q[rd_ptr];
    assign head_order      = order_q[rd_ptr];

    // a send into a full queue means upstream spent a credit it never had
    a_no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (count < wb_pkg::credit_w'(depth)));

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> head_valid);

endmodule

//--- design/load_align.sv
// ----------------------------------------------------------
// Load data aligner. Picks the byte or halfword addressed by
// the offset out of the aligned memory word and extends it
// according to the write-value select.
// ----------------------------------------------------------
`timescale 1ns/1ps

module load_align (
    input  logic [wb_pkg::xlen-1:0]     mem_rdata,
    input  logic [1:0]                  mem_offset,
    input  logic [wb_pkg::wb_sel_w-1:0] sel,
    output logic [wb_pkg::xlen-1:0]     load_data
);

    wb_pkg::mem_word_u word;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;

    assign word    = mem_rdata;
    assign ld_byte = word.bytes[mem_offset];
    assign ld_half = word.halves[mem_offset[1]]; // upper offset bit picks the half

    always_comb begin
        case (sel)
            wb_pkg::sel_lb:  load_data = {{24{ld_byte[7]}}, ld_byte};
            wb_pkg::sel_lbu: load_data = {24'b0, ld_byte};
            wb_pkg::sel_lh:  load_data = {{16{ld_half[15]}}, ld_half};
            wb_pkg::sel_lhu: load_data = {16'b0, ld_half};
            default:         load_data = mem_rdata; // lw and non-loads
        endcase
    end

    // misaligned halfwords are trapped upstream and never reach writeback
    always_comb begin
        if (sel == wb_pkg::sel_lh || sel == wb_pkg::sel_lhu)
            a_half_aligned: assert final (!mem_offset[0]);
    end

endmodule

//--- design/wb_stage.sv
// ----------------------------------------------------------
// Writeback stage. Chooses the register write value, zeroes
// it for stores, drives the register file write and produces
// one retire record per order number.
// ----------------------------------------------------------
`timescale 1ns/1ps

module wb_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          head_valid,
    input  logic                          retire_hold,
    input  logic [wb_pkg::reg_addr_w-1:0] head_rd,
    input  logic [wb_pkg::wb_sel_w-1:0]   head_sel,
    input  logic                          head_ld_reg,
    input  logic                          head_is_store,
    input  logic [wb_pkg::xlen-1:0]       head_alu_out,
    input  logic                          head_br_en,
    input  logic [wb_pkg::xlen-1:0]       head_u_imm,
    input  logic [wb_pkg::xlen-1:0]       head_pc,
    input  logic [wb_pkg::order_w-1:0]    head_order,
    input  logic [wb_pkg::xlen-1:0]       load_data,
    output logic                          pop,
    output logic                          rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [wb_pkg::xlen-1:0]       rf_wdata,
    output logic                          retire_valid,
    output logic [wb_pkg::order_w-1:0]    retire_order,
    output logic [wb_pkg::reg_addr_w-1:0] retire_rd,
    output logic [wb_pkg::xlen-1:0]       retire_wdata,
    output logic [wb_pkg::xlen-1:0]       retire_pc
);

    logic [wb_pkg::xlen-1:0]    wdata;
    logic [wb_pkg::order_w-1:0] prev_order;

    assign pop = head_valid && !retire_hold;

    // order of the last popped entry, all ones when nothing popped
    always_ff @(posedge clk) begin
        if (reset || !pop)
            prev_order <= '1;
        else
            prev_order <= head_order;
    end

    always_comb begin
        case (head_sel)
            wb_pkg::sel_alu_out:  wdata = head_alu_out;
            wb_pkg::sel_br_en:    wdata = {31'b0, head_br_en};
            wb_pkg::sel_u_imm:    wdata = head_u_imm;
            wb_pkg::sel_pc_plus4: wdata = head_pc + 32'd4;
            wb_pkg::sel_lw,
            wb_pkg::sel_lb,
            wb_pkg::sel_lbu,
            wb_pkg::sel_lh,
            wb_pkg::sel_lhu:      wdata = load_data; // already extended
            default:              wdata = head_alu_out;
        endcase
        if (head_is_store)
            wdata = '0; // stores write nothing back
    end

    assign rf_we    = pop && head_ld_reg && (head_rd != '0);
    assign rf_waddr = head_rd;
    assign rf_wdata = wdata;

    always_comb begin
        if (pop) begin
            retire_valid = (head_order != prev_order); // drop repeated order
            retire_order = head_order;
            retire_rd    = head_rd;
            retire_wdata = wdata;
            retire_pc    = head_pc;
        end else begin
            retire_valid = 1'b0;
            retire_order = '0;
            retire_rd    = '0;
            retire_wdata = '0;
            retire_pc    = wb_pkg::reset_pc;
        end
    end

    // a held entry stays at the head until it pops
    a_head_steady: assert property (@(posedge clk) disable iff (reset)
        head_valid && !pop |=> head_valid && $stable(head_order) && $stable(head_pc));

endmodule

//--- design/reg_file.sv
// ----------------------------------------------------------
// Integer register file, 32 entries with x0 tied to zero.
// One write port on the clock edge and one combinational
// read port.
// ----------------------------------------------------------
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          we,
    input  logic [wb_pkg::reg_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr,
    output logic [wb_pkg::xlen-1:0]       rdata
);

    logic [wb_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr]; // x0 always zero

endmodule

//--- design/wb_top.sv
// ----------------------------------------------------------
// Writeback and retire top level. Memory-stage results enter
// under credit flow control, retire records leave, and a read
// port exposes the register file.
// ----------------------------------------------------------
`timescale 1ns/1ps

module wb_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  logic [wb_pkg::reg_addr_w-1:0] in_rd,
    input  logic [wb_pkg::wb_sel_w-1:0]   in_sel,
    input  logic                          in_ld_reg,
    input  logic                          in_is_store,
    input  logic [wb_pkg::xlen-1:0]       in_alu_out,
    input  logic                          in_br_en,
    input  logic [wb_pkg::xlen-1:0]       in_u_imm,
    input  logic [wb_pkg::xlen-1:0]       in_mem_rdata,
    input  logic [1:0]                    in_mem_offset,
    input  logic [wb_pkg::xlen-1:0]       in_pc,
    input  logic [wb_pkg::order_w-1:0]    in_order,
    input  logic                          retire_hold,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr,
    output logic                          credit_return,
    output logic                          retire_valid,
    output logic [wb_pkg::order_w-1:0]    retire_order,
    output logic [wb_pkg::reg_addr_w-1:0] retire_rd,
    output logic [wb_pkg::xlen-1:0]       retire_wdata,
    output logic [wb_pkg::xlen-1:0]       retire_pc,
    output logic [wb_pkg::xlen-1:0]       rd_data
);

    logic                          head_valid;
    logic [wb_pkg::reg_addr_w-1:0] head_rd;
    logic [wb_pkg::wb_sel_w-1:0]   head_sel;
    logic                          head_ld_reg;
    logic                          head_is_store;
    logic [wb_pkg::xlen-1:0]       head_alu_out;
    logic                          head_br_en;
    logic [wb_pkg::xlen-1:0]       head_u_imm;
    logic [wb_pkg::xlen-1:0]       head_mem_rdata;
    logic [1:0]                    head_mem_offset;
    logic [wb_pkg::xlen-1:0]       head_pc;
    logic [wb_pkg::order_w-1:0]    head_order;
    logic [wb_pkg::xlen-1:0]       load_data;
    logic                          pop;
    logic                          rf_we;
    logic [wb_pkg::reg_addr_w-1:0] rf_waddr;
    logic [wb_pkg::xlen-1:0]       rf_wdata;

    wb_entry_queue u_queue (
        .clk, .reset, .in_valid, .in_rd, .in_sel, .in_ld_reg, .in_is_store,
        .in_alu_out, .in_br_en, .in_u_imm, .in_mem_rdata, .in_mem_offset,
        .in_pc, .in_order, .pop, .retire_hold, .head_valid, .head_rd,
        .head_sel, .head_ld_reg, .head_is_store, .head_alu_out, .head_br_en,
        .head_u_imm, .head_mem_rdata, .head_mem_offset, .head_pc, .head_order,
        .credit_return
    );

    load_align u_align (
        .mem_rdata  (head_mem_rdata),
        .mem_offset (head_mem_offset),
        .sel        (head_sel),
        .load_data  (load_data)
    );

    wb_stage u_stage (
        .clk, .reset, .head_valid, .retire_hold, .head_rd, .head_sel,
        .head_ld_reg, .head_is_store, .head_alu_out, .head_br_en, .head_u_imm,
        .head_pc, .head_order, .load_data, .pop, .rf_we, .rf_waddr, .rf_wdata,
        .retire_valid, .retire_order, .retire_rd, .retire_wdata, .retire_pc
    );

    reg_file u_rf (
        .clk   (clk),
        .reset (reset),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

//--- include/wb_ref_model.svh
// ----------------------------------------------------------
// Reference model for the writeback testbench. Holds the
// expected retire records in send order, the shadow register
// array and the duplicate-order filter. Included in the
// testbench module body.
// ----------------------------------------------------------
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

logic [wb_pkg::order_w-1:0]    exp_order [$];
logic [wb_pkg::reg_addr_w-1:0] exp_rd    [$];
logic [wb_pkg::xlen-1:0]       exp_wdata [$];
logic [wb_pkg::xlen-1:0]       exp_pc    [$];
bit                            exp_we    [$];
logic [wb_pkg::xlen-1:0]       shadow_regs [32];
logic [wb_pkg::order_w-1:0]    last_popped;
int                            load_hits [16][4]; // by select code and offset

// byte lanes counted from the low end of the word
function automatic logic [31:0] extend_load(input logic [3:0] sel, input logic [31:0] word,
                                            input logic [1:0] offset);
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    lane_b = word[8*offset +: 8];
    lane_h = word[16*offset[1] +: 16];
    case (sel)
        wb_pkg::sel_lb:  return {{24{lane_b[7]}}, lane_b};
        wb_pkg::sel_lbu: return {24'b0, lane_b};
        wb_pkg::sel_lh:  return {{16{lane_h[15]}}, lane_h};
        wb_pkg::sel_lhu: return {16'b0, lane_h};
        default:         return word;
    endcase
endfunction

function automatic void model_push(input logic [3:0] sel, input logic [4:0] rd,
                                   input bit ld_reg, input bit is_store,
                                   input logic [31:0] alu, input bit br,
                                   input logic [31:0] uimm, input logic [31:0] word,
                                   input logic [1:0] offset, input logic [31:0] pc,
                                   input logic [63:0] order);
    logic [31:0] value;
    if (is_store) begin
        value = '0;
    end else begin
        case (sel)
            wb_pkg::sel_alu_out:  value = alu;
            wb_pkg::sel_br_en:    value = {31'b0, br};
            wb_pkg::sel_u_imm:    value = uimm;
            wb_pkg::sel_pc_plus4: value = pc + 32'd4;
            default:              value = extend_load(sel, word, offset);
        endcase
        load_hits[sel][offset]++; // stores carry no load value
    end
    exp_order.push_back(order);
    exp_rd.push_back(rd);
    exp_wdata.push_back(value);
    exp_pc.push_back(pc);
    exp_we.push_back(ld_reg && (rd != 5'd0));
endfunction

// retire unless the same order popped in the cycle before
function automatic bit filter_retire(input bit popping, input logic [63:0] order);
    bit keep;
    keep = popping && (order != last_popped);
    last_popped = popping ? order : '1;
    return keep;
endfunction

`endif

//--- testbench/tb_wb_top.sv
// ----------------------------------------------------------
// Testbench for the writeback and retire top level. Sends
// random memory-stage results under the credit rule, holds
// retire in random bursts and checks every retire record,
// credit return and final register value against a model.
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_wb_top;

    logic                          clk;
    logic                          reset;
    logic                          in_valid;
    logic [wb_pkg::reg_addr_w-1:0] in_rd;
    logic [wb_pkg::wb_sel_w-1:0]   in_sel;
    logic                          in_ld_reg;
    logic                          in_is_store;
    logic [wb_pkg::xlen-1:0]       in_alu_out;
    logic                          in_br_en;
    logic [wb_pkg::xlen-1:0]       in_u_imm;
    logic [wb_pkg::xlen-1:0]       in_mem_rdata;
    logic [1:0]                    in_mem_offset;
    logic [wb_pkg::xlen-1:0]       in_pc;
    logic [wb_pkg::order_w-1:0]    in_order;
    logic                          retire_hold;
    logic [wb_pkg::reg_addr_w-1:0] rd_addr;
    logic                          credit_return;
    logic                          retire_valid;
    logic [wb_pkg::order_w-1:0]    retire_order;
    logic [wb_pkg::reg_addr_w-1:0] retire_rd;
    logic [wb_pkg::xlen-1:0]       retire_wdata;
    logic [wb_pkg::xlen-1:0]       retire_pc;
    logic [wb_pkg::xlen-1:0]       rd_data;

    integer                     seed;
    int                         errors;
    int                         credits;
    int                         sends;
    int                         returns;
    int                         pops;
    int                         retires;
    int                         hold_left;
    int                         waited;
    bit                         hold_now;
    bit                         popped_last;
    logic [wb_pkg::order_w-1:0] next_order;

    `include "wb_ref_model.svh"

    wb_top dut (.*);

    always #20 clk = ~clk;

    // one falling edge: pick hold, maybe send one entry
    task automatic drive_inputs(input bit allow_send);
        logic [31:0] r;
        logic [31:0] pick;
        @(negedge clk);
        if (hold_left == 0) begin
            r = $random(seed);
            hold_left = r[7] ? r[5:0] + 1 : r[2:0] + 1; // some bursts outlast the queue
            hold_now  = (r[10:8] < 3'd3);
        end
        hold_left--;
        retire_hold = allow_send && hold_now;
        r = $random(seed);
        if (allow_send && credits > 0 && r[1:0] != 2'd0) begin
            pick          = {$random(seed)} % 9;
            r             = $random(seed);
            in_sel        = pick[3:0];
            in_rd         = r[4:0];
            in_ld_reg     = r[5] | r[6];
            in_is_store   = (r[9:7] == 3'd0);
            in_br_en      = r[10];
            in_mem_offset = r[12:11];
            if (in_sel == wb_pkg::sel_lh || in_sel == wb_pkg::sel_lhu)
                in_mem_offset[0] = 1'b0; // halfwords stay aligned
            if (r[15:13] != 3'd0)
                next_order = next_order + 64'd1; // else repeat the last order
            in_order     = next_order;
            in_alu_out   = $random(seed);
            in_u_imm     = {$random(seed)} & 32'hffff_f000;
            in_mem_rdata = $random(seed);
            in_pc        = {$random(seed)} & 32'hffff_fffc;
            in_valid     = 1'b1;
            credits--;
            sends++;
        end else begin
            in_valid = 1'b0;
        end
    endtask

    // sampled mid low phase, before the edge that pops
    task automatic check_cycle();
        bit                            pop_exp;
        bit                            valid_exp;
        logic [wb_pkg::order_w-1:0]    order_exp;
        logic [wb_pkg::reg_addr_w-1:0] rd_exp;
        logic [wb_pkg::xlen-1:0]       wdata_exp;
        logic [wb_pkg::xlen-1:0]       pc_exp;
        bit                            we_exp;
        pop_exp = (exp_order.size() > 0) && !retire_hold;
        if (credit_return !== popped_last) begin
            errors++;
            $display("error credit_return: expected %h actual %h", popped_last, credit_return);
        end
        if (credit_return === 1'b1) begin
            credits++;
            returns++;
        end
        order_exp = 64'd0;
        rd_exp    = 5'd0;
        wdata_exp = 32'd0;
        pc_exp    = wb_pkg::reset_pc; // idle record
        we_exp    = 1'b0;
        if (pop_exp) begin
            order_exp = exp_order.pop_front();
            rd_exp    = exp_rd.pop_front();
            wdata_exp = exp_wdata.pop_front();
            pc_exp    = exp_pc.pop_front();
            we_exp    = exp_we.pop_front();
            pops++;
        end
        valid_exp = filter_retire(pop_exp, order_exp);
        if (valid_exp)
            retires++;
        if (retire_valid !== valid_exp) begin
            errors++;
            $display("error retire_valid: expected %h actual %h", valid_exp, retire_valid);
        end
        if (retire_order !== order_exp) begin
            errors++;
            $display("error retire_order: expected %h actual %h", order_exp, retire_order);
        end
        if (retire_rd !== rd_exp) begin
            errors++;
            $display("error retire_rd: expected %h actual %h", rd_exp, retire_rd);
        end
        if (retire_wdata !== wdata_exp) begin
            errors++;
            $display("error retire_wdata: expected %h actual %h", wdata_exp, retire_wdata);
        end
        if (retire_pc !== pc_exp) begin
            errors++;
            $display("error retire_pc: expected %h actual %h", pc_exp, retire_pc);
        end
        if (we_exp)
            shadow_regs[rd_exp] = wdata_exp;
        popped_last = pop_exp;
    endtask

    task automatic run_cycle(input bit allow_send);
        drive_inputs(allow_send);
        #10;
        check_cycle();
        if (in_valid)
            model_push(in_sel, in_rd, in_ld_reg, in_is_store, in_alu_out, in_br_en,
                       in_u_imm, in_mem_rdata, in_mem_offset, in_pc, in_order);
        if (credits > wb_pkg::wb_queue_depth) begin
            errors++;
            $display("more credits came back than entries were sent: %0d credits held",
                     credits);
        end
    endtask

    initial begin
        seed          = 32'h42de_7257;
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_rd         = '0;
        in_sel        = '0;
        in_ld_reg     = 1'b0;
        in_is_store   = 1'b0;
        in_alu_out    = '0;
        in_br_en      = 1'b0;
        in_u_imm      = '0;
        in_mem_rdata  = '0;
        in_mem_offset = '0;
        in_pc         = '0;
        in_order      = '0;
        retire_hold   = 1'b0;
        rd_addr       = '0;
        credits       = wb_pkg::wb_queue_depth;
        next_order    = 64'h0000_0003_ffff_fff0; // crosses the 32-bit boundary
        last_popped   = '1;
        for (int i = 0; i < 32; i++)
            shadow_regs[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #10;
        if (retire_valid !== 1'b0) begin
            errors++;
            $display("error idle_retire_valid: expected 0 actual %b", retire_valid);
        end
        if (credit_return !== 1'b0) begin
            errors++;
            $display("error idle_credit_return: expected 0 actual %b", credit_return);
        end
        if (retire_pc !== wb_pkg::reset_pc) begin
            errors++;
            $display("error idle_retire_pc: expected %h actual %h", wb_pkg::reset_pc, retire_pc);
        end
        for (int c = 0; c < 2000; c++)
            run_cycle(1'b1);
        waited = 0;
        while ((exp_order.size() > 0 || credits != wb_pkg::wb_queue_depth) && waited < 200) begin
            run_cycle(1'b0);
            waited++;
        end
        if (waited >= 200) begin
            errors++;
            $display("timeout: queue did not drain or credits did not come back");
        end
        if (returns != sends || pops != sends) begin
            errors++;
            $display("entry count mismatch: %0d sent, %0d popped, %0d credits back",
                     sends, pops, returns);
        end
        if (pops == retires) begin
            errors++;
            $display("no repeated order ever popped back to back, filter never exercised");
        end
        for (int s = int'(wb_pkg::sel_lb); s <= int'(wb_pkg::sel_lhu); s++)
            for (int o = 0; o < 4; o++)
                if (load_hits[s][o] == 0 && (s < int'(wb_pkg::sel_lh) || o % 2 == 0)) begin
                    errors++;
                    $display("load select %0d never seen at offset %0d", s, o);
                end
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            rd_addr = 5'(i);
            #10;
            if (rd_data !== shadow_regs[i]) begin
                errors++;
                $display("error reg_x%0d: expected %h actual %h", i, shadow_regs[i], rd_data);
            end
        end
        $display("sends %0d retires %0d credits %0d errors %0d", sends, retires, returns, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
design/wb_pkg.sv
design/wb_entry_queue.sv
design/load_align.sv
design/wb_stage.sv
design/reg_file.sv
design/wb_top.sv
testbench/tb_wb_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_wb_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) include/wb_ref_model.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
